// ==== source/periph_bus_pkg.sv ====
//**********************************************************************
// peripheral bus package
// bus word types, target indices, address map and the chip identifier
// shared by the address decoder, the peripherals and the testbench
//**********************************************************************

package periph_bus_pkg;

    // one APB byte address and one bus data word
    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register offset inside a peripheral region, the low address bits
    typedef logic [7:0] reg_offset_t;

    //**********************************************************************
    // targets behind the node
    //**********************************************************************
    localparam int unsigned NB_TARGET    = 3;

    localparam int unsigned TGT_SOC_CTRL = 0;
    localparam int unsigned TGT_GPIO     = 1;
    localparam int unsigned TGT_TIMER    = 2;

    //**********************************************************************
    // address map, 4 KiB per region
    //**********************************************************************
    localparam apb_addr_t SOC_CTRL_START_ADDR = 32'h1A10_0000;
    localparam apb_addr_t SOC_CTRL_END_ADDR   = 32'h1A10_0FFF;

    localparam apb_addr_t GPIO_START_ADDR     = 32'h1A10_1000;
    localparam apb_addr_t GPIO_END_ADDR       = 32'h1A10_1FFF;

    localparam apb_addr_t TIMER_START_ADDR    = 32'h1A10_2000;
    localparam apb_addr_t TIMER_END_ADDR      = 32'h1A10_2FFF;

    // identification word returned at offset 0 of the SoC control block
    localparam apb_data_t CHIP_ID = 32'h5043_0001;

endpackage

// ==== source/apb_node.sv ====
//**********************************************************************
// APB address decoding node
// routes one transfer to the target whose region holds paddr and
// multiplexes the response back, unmapped accesses end with an error
//**********************************************************************

`timescale 1ns/1ps

module apb_node (
    input  logic                          clk_i,
    input  logic                          arst_n,
    // initiator side
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  periph_bus_pkg::apb_addr_t     paddr,
    input  periph_bus_pkg::apb_data_t     pwdata,
    output periph_bus_pkg::apb_data_t     prdata,
    output logic                          pready,
    output logic                          pslverr,
    // target side
    output logic                          soc_sel,
    output logic                          gpio_sel,
    output logic                          timer_sel,
    output logic                          tgt_penable,
    output logic                          tgt_pwrite,
    output periph_bus_pkg::reg_offset_t   tgt_offset,
    output periph_bus_pkg::apb_data_t     tgt_wdata,
    input  periph_bus_pkg::apb_data_t     soc_rdata,
    input  periph_bus_pkg::apb_data_t     gpio_rdata,
    input  logic                          gpio_ready,
    input  periph_bus_pkg::apb_data_t     timer_rdata
);

    logic [periph_bus_pkg::NB_TARGET-1:0] hit;
    logic                                 access;
    logic                                 miss;
    logic                                 miss_q;

    // regions do not overlap, so at most one hit bit is set
    assign hit[periph_bus_pkg::TGT_SOC_CTRL] = psel
        && (paddr >= periph_bus_pkg::SOC_CTRL_START_ADDR)
        && (paddr <= periph_bus_pkg::SOC_CTRL_END_ADDR);
    assign hit[periph_bus_pkg::TGT_GPIO]     = psel
        && (paddr >= periph_bus_pkg::GPIO_START_ADDR)
        && (paddr <= periph_bus_pkg::GPIO_END_ADDR);
    assign hit[periph_bus_pkg::TGT_TIMER]    = psel
        && (paddr >= periph_bus_pkg::TIMER_START_ADDR)
        && (paddr <= periph_bus_pkg::TIMER_END_ADDR);

    assign access = psel && penable;
    assign miss   = psel && (hit == '0);

    assign soc_sel   = hit[periph_bus_pkg::TGT_SOC_CTRL];
    assign gpio_sel  = hit[periph_bus_pkg::TGT_GPIO];
    assign timer_sel = hit[periph_bus_pkg::TGT_TIMER];

    // control and write data go to every target, only the select differs
    assign tgt_penable = penable;
    assign tgt_pwrite  = pwrite;
    assign tgt_offset  = paddr[7:0];
    assign tgt_wdata   = pwdata;

    // the miss is captured in the setup cycle and dropped once answered
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            miss_q <= 1'b0;
        end else if (psel && !penable) begin
            miss_q <= miss;
        end else if (access && miss_q) begin
            miss_q <= 1'b0;
        end
    end

    //**********************************************************************
    // response multiplexer
    //**********************************************************************
    always_comb begin
        prdata = '0;
        pready = 1'b0;
        if (soc_sel) begin
            prdata = soc_rdata;
            pready = penable;
        end else if (gpio_sel) begin
            prdata = gpio_rdata;
            pready = penable && gpio_ready;
        end else if (timer_sel) begin
            prdata = timer_rdata;
            pready = penable;
        end else if (access && miss_q) begin
            pready = 1'b1;
        end
    end

    assign pslverr = access && miss_q;

endmodule

// ==== source/soc_ctrl_regs.sv ====
//**********************************************************************
// SoC control registers
// read-only identification word and two scratch registers
//**********************************************************************

`timescale 1ns/1ps

module soc_ctrl_regs (
    input  logic                          clk_i,
    input  logic                          arst_n,
    input  logic                          sel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  periph_bus_pkg::reg_offset_t   offset,
    input  periph_bus_pkg::apb_data_t     wdata,
    output periph_bus_pkg::apb_data_t     rdata
);

    periph_bus_pkg::apb_data_t scratch0_q;
    periph_bus_pkg::apb_data_t scratch1_q;
    logic                      wr_en;

    // zero wait states, the write lands at the end of the first access cycle
    assign wr_en = sel && penable && pwrite;

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            scratch0_q <= '0;
            scratch1_q <= '0;
        end else if (wr_en) begin
            if (offset == 8'h04) begin
                scratch0_q <= wdata;
            end
            if (offset == 8'h08) begin
                scratch1_q <= wdata;
            end
        end
    end

    always_comb begin
        case (offset)
            8'h00:   rdata = periph_bus_pkg::CHIP_ID;
            8'h04:   rdata = scratch0_q;
            8'h08:   rdata = scratch1_q;
            default: rdata = '0;
        endcase
    end

endmodule

// ==== source/gpio_regs.sv ====
//**********************************************************************
// GPIO registers
// direction, output with set and clear aliases, synchronized input
// every transfer takes one wait state
//**********************************************************************

`timescale 1ns/1ps

module gpio_regs #(
    parameter int unsigned NB_GPIO = 16
) (
    input  logic                          clk_i,
    input  logic                          arst_n,
    input  logic                          sel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  periph_bus_pkg::reg_offset_t   offset,
    input  periph_bus_pkg::apb_data_t     wdata,
    output periph_bus_pkg::apb_data_t     rdata,
    output logic                          ready,
    input  logic [NB_GPIO-1:0]            gpio_in,
    output logic [NB_GPIO-1:0]            gpio_out,
    output logic [NB_GPIO-1:0]            gpio_oe
);

    logic [NB_GPIO-1:0]        dir_q;
    logic [NB_GPIO-1:0]        out_q;
    logic [NB_GPIO-1:0]        in_meta_q;
    logic [NB_GPIO-1:0]        in_q;
    logic                      wait_q;
    logic                      wr_en;
    periph_bus_pkg::apb_data_t rd_next;

    // wait_q is high only in the second access cycle, which completes
    assign wr_en = sel && penable && pwrite && wait_q;
    assign ready = wait_q;

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            wait_q    <= 1'b0;
            dir_q     <= '0;
            out_q     <= '0;
            in_meta_q <= '0;
            in_q      <= '0;
        end else begin
            wait_q    <= sel && penable && !wait_q;
            in_meta_q <= gpio_in;
            in_q      <= in_meta_q;
            if (wr_en) begin
                case (offset)
                    8'h00:   dir_q <= wdata[NB_GPIO-1:0];
                    8'h04:   out_q <= wdata[NB_GPIO-1:0];
                    8'h0C:   out_q <= out_q | wdata[NB_GPIO-1:0];
                    8'h10:   out_q <= out_q & ~wdata[NB_GPIO-1:0];
                    default: ;
                endcase
            end
        end
    end

    // bits above NB_GPIO stay zero
    always_comb begin
        rd_next = '0;
        case (offset)
            8'h00:   rd_next[NB_GPIO-1:0] = dir_q;
            8'h04:   rd_next[NB_GPIO-1:0] = out_q;
            8'h08:   rd_next[NB_GPIO-1:0] = in_q;
            default: rd_next = '0;
        endcase
    end

    // read data is sampled in the first access cycle for the second one
    always_ff @(posedge clk_i) begin
        if (sel && penable && !wait_q) begin
            rdata <= rd_next;
        end
    end

    assign gpio_out = out_q;
    assign gpio_oe  = dir_q;

endmodule

// ==== source/apb_timer_unit.sv ====
//**********************************************************************
// compare timer
// free-running counter with compare, sticky match flag and interrupt
//**********************************************************************

`timescale 1ns/1ps

module apb_timer_unit (
    input  logic                          clk_i,
    input  logic                          arst_n,
    input  logic                          sel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  periph_bus_pkg::reg_offset_t   offset,
    input  periph_bus_pkg::apb_data_t     wdata,
    output periph_bus_pkg::apb_data_t     rdata,
    output logic                          irq
);

    // ctrl_q[0] enables counting, ctrl_q[1] restarts from zero on a match
    logic [1:0]                ctrl_q;
    periph_bus_pkg::apb_data_t count_q;
    periph_bus_pkg::apb_data_t cmp_q;
    logic                      match_q;
    logic                      wr_en;
    logic                      hit;

    assign wr_en = sel && penable && pwrite;
    assign hit   = ctrl_q[0] && (count_q == cmp_q);

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q  <= '0;
            count_q <= '0;
            cmp_q   <= '0;
            match_q <= 1'b0;
        end else begin
            if (wr_en && offset == 8'h00) begin
                ctrl_q <= wdata[1:0];
            end
            if (wr_en && offset == 8'h08) begin
                cmp_q <= wdata;
            end

            // a bus write wins over the increment
            if (wr_en && offset == 8'h04) begin
                count_q <= wdata;
            end else if (hit && ctrl_q[1]) begin
                count_q <= '0;
            end else if (ctrl_q[0]) begin
                count_q <= count_q + 32'd1;
            end

            // a new match is not lost to a clear in the same cycle
            if (hit) begin
                match_q <= 1'b1;
            end else if (wr_en && offset == 8'h0C && wdata[0]) begin
                match_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (offset)
            8'h00:   rdata[1:0] = ctrl_q;
            8'h04:   rdata = count_q;
            8'h08:   rdata = cmp_q;
            8'h0C:   rdata[0] = match_q;
            default: rdata = '0;
        endcase
    end

    assign irq = match_q;

endmodule

// ==== source/periph_bus_wrap.sv ====
//**********************************************************************
// peripheral bus top level
// APB node with SoC control, GPIO and timer targets behind it
//**********************************************************************

`timescale 1ns/1ps

module periph_bus_wrap #(
    parameter int unsigned NB_GPIO = 16
) (
    input  logic                          clk_i,
    input  logic                          arst_n,
    // APB port from the interconnect
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  periph_bus_pkg::apb_addr_t     paddr,
    input  periph_bus_pkg::apb_data_t     pwdata,
    output periph_bus_pkg::apb_data_t     prdata,
    output logic                          pready,
    output logic                          pslverr,
    // chip pins
    input  logic [NB_GPIO-1:0]            gpio_in,
    output logic [NB_GPIO-1:0]            gpio_out,
    output logic [NB_GPIO-1:0]            gpio_oe,
    output logic                          timer_irq
);

    logic [periph_bus_pkg::NB_TARGET-1:0] tgt_sel;
    periph_bus_pkg::apb_data_t            tgt_rdata [periph_bus_pkg::NB_TARGET];
    logic                                 gpio_ready;
    logic                                 tgt_penable;
    logic                                 tgt_pwrite;
    periph_bus_pkg::reg_offset_t          tgt_offset;
    periph_bus_pkg::apb_data_t            tgt_wdata;

    //**********************************************************************
    // address decoding node
    //**********************************************************************
    apb_node apb_node_inst (
        .clk_i       ( clk_i                                   ),
        .arst_n      ( arst_n                                  ),
        .psel        ( psel                                    ),
        .penable     ( penable                                 ),
        .pwrite      ( pwrite                                  ),
        .paddr       ( paddr                                   ),
        .pwdata      ( pwdata                                  ),
        .prdata      ( prdata                                  ),
        .pready      ( pready                                  ),
        .pslverr     ( pslverr                                 ),
        .soc_sel     ( tgt_sel[periph_bus_pkg::TGT_SOC_CTRL]   ),
        .gpio_sel    ( tgt_sel[periph_bus_pkg::TGT_GPIO]       ),
        .timer_sel   ( tgt_sel[periph_bus_pkg::TGT_TIMER]      ),
        .tgt_penable ( tgt_penable                             ),
        .tgt_pwrite  ( tgt_pwrite                              ),
        .tgt_offset  ( tgt_offset                              ),
        .tgt_wdata   ( tgt_wdata                               ),
        .soc_rdata   ( tgt_rdata[periph_bus_pkg::TGT_SOC_CTRL] ),
        .gpio_rdata  ( tgt_rdata[periph_bus_pkg::TGT_GPIO]     ),
        .gpio_ready  ( gpio_ready                              ),
        .timer_rdata ( tgt_rdata[periph_bus_pkg::TGT_TIMER]    )
    );

    //**********************************************************************
    // targets
    //**********************************************************************
    soc_ctrl_regs soc_ctrl_regs_inst (
        .clk_i   ( clk_i                                   ),
        .arst_n  ( arst_n                                  ),
        .sel     ( tgt_sel[periph_bus_pkg::TGT_SOC_CTRL]   ),
        .penable ( tgt_penable                             ),
        .pwrite  ( tgt_pwrite                              ),
        .offset  ( tgt_offset                              ),
        .wdata   ( tgt_wdata                               ),
        .rdata   ( tgt_rdata[periph_bus_pkg::TGT_SOC_CTRL] )
    );

    gpio_regs #(
        .NB_GPIO ( NB_GPIO )
    ) gpio_regs_inst (
        .clk_i    ( clk_i                               ),
        .arst_n   ( arst_n                              ),
        .sel      ( tgt_sel[periph_bus_pkg::TGT_GPIO]   ),
        .penable  ( tgt_penable                         ),
        .pwrite   ( tgt_pwrite                          ),
        .offset   ( tgt_offset                          ),
        .wdata    ( tgt_wdata                           ),
        .rdata    ( tgt_rdata[periph_bus_pkg::TGT_GPIO] ),
        .ready    ( gpio_ready                          ),
        .gpio_in  ( gpio_in                             ),
        .gpio_out ( gpio_out                            ),
        .gpio_oe  ( gpio_oe                             )
    );

    apb_timer_unit apb_timer_unit_inst (
        .clk_i   ( clk_i                                ),
        .arst_n  ( arst_n                               ),
        .sel     ( tgt_sel[periph_bus_pkg::TGT_TIMER]   ),
        .penable ( tgt_penable                          ),
        .pwrite  ( tgt_pwrite                           ),
        .offset  ( tgt_offset                           ),
        .wdata   ( tgt_wdata                            ),
        .rdata   ( tgt_rdata[periph_bus_pkg::TGT_TIMER] ),
        .irq     ( timer_irq                            )
    );

endmodule

// ==== bench/tb_periph_bus.sv ====
//**********************************************************************
// peripheral bus testbench
// plays the stimulus file over the APB port, checks read data, error
// responses and pins, then runs random scratch register round trips
//**********************************************************************

`timescale 1ns/1ps

module tb_periph_bus;

    localparam int unsigned NB_GPIO       = 16;
    localparam int unsigned CLK_PERIOD    = 10;
    localparam int unsigned SAMPLE_DELAY  = 1;
    localparam int unsigned RESET_CYCLES  = 16;
    localparam int unsigned READY_LIMIT   = 20;
    localparam int unsigned GPIO_SETTLE   = 4;
    localparam int unsigned NB_RANDOM     = 20;
    localparam string       STIMULUS_FILE = "bench/periph_bus_stimulus.txt";

    logic                      clk_i;
    logic                      arst_n;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    periph_bus_pkg::apb_addr_t paddr;
    periph_bus_pkg::apb_data_t pwdata;
    periph_bus_pkg::apb_data_t prdata;
    logic                      pready;
    logic                      pslverr;
    logic [NB_GPIO-1:0]        gpio_in;
    logic [NB_GPIO-1:0]        gpio_out;
    logic [NB_GPIO-1:0]        gpio_oe;
    logic                      timer_irq;

    int unsigned               error_count;
    int unsigned               timeout_count;
    logic [31:0]               rnd_state;

    periph_bus_wrap #(
        .NB_GPIO ( NB_GPIO )
    ) periph_bus_wrap_inst (
        .clk_i     ( clk_i     ),
        .arst_n    ( arst_n    ),
        .psel      ( psel      ),
        .penable   ( penable   ),
        .pwrite    ( pwrite    ),
        .paddr     ( paddr     ),
        .pwdata    ( pwdata    ),
        .prdata    ( prdata    ),
        .pready    ( pready    ),
        .pslverr   ( pslverr   ),
        .gpio_in   ( gpio_in   ),
        .gpio_out  ( gpio_out  ),
        .gpio_oe   ( gpio_oe   ),
        .timer_irq ( timer_irq )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    //**********************************************************************
    // APB transfer, setup cycle then access cycles until pready
    //**********************************************************************
    task automatic apb_transfer(input logic wr, input periph_bus_pkg::apb_addr_t addr,
                                input periph_bus_pkg::apb_data_t data,
                                output periph_bus_pkg::apb_data_t rdata, output logic err);
        int unsigned waited;
        int unsigned expected_waits;
        waited = 0;
        rdata  = '0;
        err    = 1'b0;
        // only the GPIO block adds a wait state
        if (addr >= periph_bus_pkg::GPIO_START_ADDR &&
            addr <= periph_bus_pkg::GPIO_END_ADDR) begin
            expected_waits = 1;
        end else begin
            expected_waits = 0;
        end
        @(negedge clk_i);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        #SAMPLE_DELAY;
        check_equal(pready, 1'b0, $sformatf("pready in the setup cycle to %h", addr));
        @(negedge clk_i);
        penable = 1'b1;
        // responses are sampled well before the completing rising edge
        #SAMPLE_DELAY;
        while (pready !== 1'b1 && waited < READY_LIMIT) begin
            @(negedge clk_i);
            #SAMPLE_DELAY;
            waited++;
        end
        if (pready === 1'b1) begin
            rdata = prdata;
            err   = pslverr;
            check_equal(waited, expected_waits,
                        $sformatf("wait states of the transfer to %h", addr));
        end else begin
            timeout_count++;
            $display("timeout: no pready within %0d cycles for the transfer to %h",
                     READY_LIMIT, addr);
        end
        @(negedge clk_i);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_operation(input byte op, input logic [31:0] addr,
                                 input logic [31:0] data, input logic [31:0] expected);
        periph_bus_pkg::apb_data_t rd;
        logic                      err;
        int unsigned               cycles;
        cycles = 0;
        case (op)
            "W": begin
                apb_transfer(1'b1, addr, data, rd, err);
                check_equal(err, 1'b0, $sformatf("pslverr on write to %h", addr));
            end
            "R": begin
                apb_transfer(1'b0, addr, '0, rd, err);
                check_equal(rd & data, expected, $sformatf("read data at %h", addr));
                check_equal(err, 1'b0, $sformatf("pslverr on read from %h", addr));
            end
            "E": begin
                apb_transfer(1'b0, addr, '0, rd, err);
                check_equal(err, 1'b1, $sformatf("pslverr on access to %h", addr));
                check_equal(rd, expected, $sformatf("error read data at %h", addr));
            end
            "G": begin
                @(negedge clk_i);
                gpio_in = data[NB_GPIO-1:0];
                repeat (GPIO_SETTLE) @(negedge clk_i);
            end
            "P": begin
                @(negedge clk_i);
                check_equal(gpio_oe, data, "gpio_oe pins");
                check_equal(gpio_out, expected, "gpio_out pins");
            end
            "I": begin
                while (timer_irq !== expected[0] && cycles < data) begin
                    @(negedge clk_i);
                    cycles++;
                end
                if (timer_irq !== expected[0]) begin
                    timeout_count++;
                    $display("timeout: timer_irq did not reach %0b within %0d cycles",
                             expected[0], data);
                end
            end
            default: begin
                error_count++;
                $display("unknown opcode %c in the stimulus file", op);
            end
        endcase
    endtask

    // both scratch registers are modelled and read back, so a write that lands in
    // the wrong register shows up
    task automatic scratch_random_pairs();
        periph_bus_pkg::apb_addr_t addr;
        periph_bus_pkg::apb_addr_t other_addr;
        periph_bus_pkg::apb_data_t rd;
        periph_bus_pkg::apb_data_t model [2];
        logic                      err;
        int                        i;
        int                        slot;
        for (i = 0; i < NB_RANDOM && timeout_count == 0; i++) begin
            rnd_state   = xorshift32(rnd_state);
            slot        = i % 2;
            addr        = periph_bus_pkg::SOC_CTRL_START_ADDR + ((slot == 0) ? 32'h4 : 32'h8);
            other_addr  = periph_bus_pkg::SOC_CTRL_START_ADDR + ((slot == 0) ? 32'h8 : 32'h4);
            model[slot] = rnd_state;
            apb_transfer(1'b1, addr, model[slot], rd, err);
            check_equal(err, 1'b0, $sformatf("pslverr on write to %h", addr));
            apb_transfer(1'b0, addr, '0, rd, err);
            check_equal(rd, model[slot], $sformatf("scratch readback at %h", addr));
            check_equal(err, 1'b0, $sformatf("pslverr on read from %h", addr));
            if (i > 0) begin
                apb_transfer(1'b0, other_addr, '0, rd, err);
                check_equal(rd, model[1 - slot],
                            $sformatf("scratch readback at %h", other_addr));
            end
        end
    endtask

    //**********************************************************************
    // main sequence
    //**********************************************************************
    initial begin
        int          fd;
        int          c;
        int          n;
        byte         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expected;
        error_count   = 0;
        timeout_count = 0;
        rnd_state     = 32'hb31b;
        clk_i         = 1'b0;
        arst_n        = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        gpio_in       = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        arst_n = 1'b1;
        @(negedge clk_i);

        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open the stimulus file %s", STIMULUS_FILE);
        end else begin
            c = $fgetc(fd);
            while (c != -1 && timeout_count == 0) begin
                if (c == "#") begin
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (c != "\n" && c != "\r" && c != " " && c != "\t") begin
                    op = byte'(c);
                    n  = $fscanf(fd, "%h %h %h", addr, data, expected);
                    if (n != 3) begin
                        error_count++;
                        $display("malformed stimulus line for opcode %c", op);
                    end else begin
                        run_operation(op, addr, data, expected);
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            if (timeout_count == 0) begin
                scratch_random_pairs();
            end
        end

        $display("closing: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
source/periph_bus_pkg.sv
source/apb_node.sv
source/soc_ctrl_regs.sv
source/gpio_regs.sv
source/apb_timer_unit.sv
source/periph_bus_wrap.sv
bench/tb_periph_bus.sv

// ==== Bender.yml ====
package:
  name: periph_bus

sources:
  - source/periph_bus_pkg.sv
  - source/apb_node.sv
  - source/soc_ctrl_regs.sv
  - source/gpio_regs.sv
  - source/apb_timer_unit.sv
  - source/periph_bus_wrap.sv
  - target: test
    files:
      - bench/tb_periph_bus.sv

// ==== bench/periph_bus_stimulus.txt ====
# columns: opcode address data expected, all values in hex
# R compares read data masked by data, P checks gpio_oe=data gpio_out=expected, I waits data cycles
R 1A100000 FFFFFFFF 50430001
R 1A100004 FFFFFFFF 00000000
R 1A100008 FFFFFFFF 00000000
R 1A101000 FFFFFFFF 00000000
R 1A101004 FFFFFFFF 00000000
P 00000000 00000000 00000000
I 00000000 00000001 00000000
W 1A100004 A5A55A5A 00000000
R 1A100004 FFFFFFFF A5A55A5A
W 1A100008 12345678 00000000
R 1A100008 FFFFFFFF 12345678
W 1A101000 000100FF 00000000
R 1A101000 FFFFFFFF 000000FF
W 1A101004 FFFF1234 00000000
R 1A101004 FFFFFFFF 00001234
W 1A10100C 00000F00 00000000
W 1A101010 00000034 00000000
R 1A101004 FFFFFFFF 00001F00
P 00000000 000000FF 00001F00
G 00000000 0000BEEF 00000000
R 1A101008 FFFFFFFF 0000BEEF
# timer with compare 40, restart on match
W 1A102008 00000028 00000000
W 1A102004 00000000 00000000
W 1A102000 00000003 00000000
I 00000000 00000064 00000001
R 1A10200C FFFFFFFF 00000001
W 1A10200C 00000001 00000000
I 00000000 00000002 00000000
R 1A102004 FFFFFFE0 00000000
E 1A108000 00000000 00000000
R 1A100000 FFFFFFFF 50430001
